/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f spi_master.f \
    --top-module spi_master_tb -o spi_master_sim || { echo "Build failed"; exit 1; }
output="$(./obj_dir/spi_master_sim)"
echo "$output"
echo "$output" | grep -qx "ALL TESTS PASSED" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* source/spi_clock_divider.sv */
`timescale 1ns/1ps

module spi_clock_divider (
    input  logic              clock,
    input  logic              reset,
    input  logic              run,
    input  spi_pkg::divider_t divider,
    output logic              edge_tick
);

    // Longest half period is 256 cycles
    localparam int COUNT_WIDTH = 8;

    logic [COUNT_WIDTH-1:0] count;
    logic [COUNT_WIDTH-1:0] terminal_count;

    // 2**(divider+1) - 1
    assign terminal_count = COUNT_WIDTH'((9'd2 << divider) - 9'd1);

    assign edge_tick = run && (count == terminal_count);

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
        end else if (!run) begin
            // Restart so the first tick comes a full half period after run
            count <= '0;
        end else if (count == terminal_count) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

/* source/spi_control_unit.sv */
`timescale 1ns/1ps

module spi_control_unit #(
    parameter spi_pkg::spi_word_t BASE_ADDRESS = 32'h43c0_0000,
    parameter bit SS_POLARITY_DEFAULT = 1'b0,
    parameter int REGISTER_COUNT = 8
) (
    input  logic                  clock,
    input  logic                  reset,
    input  spi_pkg::spi_word_t    sb_address,
    input  spi_pkg::spi_word_t    sb_write_data,
    input  logic                  sb_write_strobe,
    input  logic                  sb_read_strobe,
    input  logic                  write_valid,
    input  spi_pkg::spi_word_t    write_data,
    input  spi_pkg::spi_word_t    file_read_data,
    input  logic                  done,
    input  spi_pkg::spi_word_t    rx_data,
    output spi_pkg::spi_word_t    sb_read_data,
    output logic                  sb_ready,
    output logic                  write_ready,
    output logic                  file_write_enable,
    output spi_pkg::spi_address_t file_address,
    output spi_pkg::spi_word_t    file_write_data,
    output logic                  start,
    output spi_pkg::spi_word_t    tx_data,
    output spi_pkg::length_t      length,
    output spi_pkg::divider_t     divider,
    output logic                  clock_polarity,
    output logic                  ss_polarity
);
    import spi_pkg::*;

    control_state_t state;
    spi_word_t bus_offset;
    spi_address_t latched_offset;
    spi_word_t latched_data;
    logic latched_in_map;
    logic read_active;
    logic bus_accept;

    assign bus_offset = sb_address - BASE_ADDRESS;

    // A stream word wins over a strobe in the same cycle
    assign bus_accept = (state == control_idle) && sb_ready && !write_valid
                        && (sb_write_strobe || sb_read_strobe);

    assign write_ready = sb_ready;

    // Latched access for the write or read that follows
    always_ff @(posedge clock) begin
        if (bus_accept) begin
            latched_offset <= bus_offset[7:0];
            latched_data <= sb_write_data;
            latched_in_map <= bus_offset < spi_word_t'(REGISTER_COUNT * 4);
        end
    end

    // Readback copy, RX data is read only
    assign file_address = latched_offset;
    assign file_write_data = latched_data;
    assign file_write_enable = (state == control_bus_write) && latched_in_map
                               && (latched_offset != RX_DATA_OFFSET);

    always_comb begin
        if (!read_active || !latched_in_map) begin
            sb_read_data = '0;
        end else if (latched_offset == RX_DATA_OFFSET) begin
            sb_read_data = rx_data;
        end else begin
            sb_read_data = file_read_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= control_idle;
            sb_ready <= 1'b1;
            read_active <= 1'b0;
            start <= 1'b0;
            tx_data <= '0;
            length <= 5'd31;
            divider <= '0;
            clock_polarity <= 1'b0;
            ss_polarity <= SS_POLARITY_DEFAULT;
        end else begin
            start <= 1'b0;
            read_active <= 1'b0;
            case (state)
                control_idle: begin
                    if (!sb_ready) begin
                        // Closing cycle of a read or a register write
                        sb_ready <= 1'b1;
                    end else if (write_valid) begin
                        tx_data <= write_data;
                        sb_ready <= 1'b0;
                        state <= control_start_transfer;
                    end else if (sb_write_strobe) begin
                        sb_ready <= 1'b0;
                        if (bus_offset == START_OFFSET) begin
                            state <= control_start_transfer;
                        end else begin
                            state <= control_bus_write;
                        end
                    end else if (sb_read_strobe) begin
                        sb_ready <= 1'b0;
                        read_active <= 1'b1;
                    end
                end
                control_bus_write: begin
                    if (latched_in_map) begin
                        case (latched_offset)
                            CONTROL_OFFSET: begin
                                divider <= latched_data[2:0];
                                length <= latched_data[7:3];
                                clock_polarity <= latched_data[8];
                                ss_polarity <= latched_data[9];
                            end
                            TX_DATA_OFFSET: begin
                                tx_data <= latched_data;
                            end
                            default: begin
                                // Plain storage, register file only
                            end
                        endcase
                    end
                    state <= control_idle;
                end
                control_start_transfer: begin
                    start <= 1'b1;
                    state <= control_transfer_busy;
                end
                control_transfer_busy: begin
                    if (done) begin
                        sb_ready <= 1'b1;
                        state <= control_idle;
                    end
                end
                default: begin
                    state <= control_idle;
                end
            endcase
        end
    end

endmodule

/* source/spi_master.sv */
`timescale 1ns/1ps

module spi_master #(
    parameter spi_pkg::spi_word_t BASE_ADDRESS = 32'h43c0_0000,
    parameter bit SS_POLARITY_DEFAULT = 1'b0,
    parameter int REGISTER_COUNT = 8
) (
    input  logic               clock,
    input  logic               reset,
    input  spi_pkg::spi_word_t sb_address,
    input  spi_pkg::spi_word_t sb_write_data,
    input  logic               sb_write_strobe,
    input  logic               sb_read_strobe,
    input  logic               write_valid,
    input  spi_pkg::spi_word_t write_data,
    input  logic               miso,
    output spi_pkg::spi_word_t sb_read_data,
    output logic               sb_ready,
    output logic               write_ready,
    output logic               sclk,
    output logic               mosi,
    output logic               ss
);
    import spi_pkg::*;

    // Register file port
    logic file_write_enable;
    spi_address_t file_address;
    spi_word_t file_write_data;
    spi_word_t file_read_data;

    // Transfer settings and handshake
    logic start;
    logic done;
    spi_word_t tx_data;
    spi_word_t rx_data;
    length_t length;
    divider_t divider;
    logic clock_polarity;
    logic ss_polarity;

    // Serial clock timing
    logic run;
    logic edge_tick;

    spi_control_unit #(
        .BASE_ADDRESS(BASE_ADDRESS),
        .SS_POLARITY_DEFAULT(SS_POLARITY_DEFAULT),
        .REGISTER_COUNT(REGISTER_COUNT)
    ) spi_control_unit_inst (
        .clock(clock),
        .reset(reset),
        .sb_address(sb_address),
        .sb_write_data(sb_write_data),
        .sb_write_strobe(sb_write_strobe),
        .sb_read_strobe(sb_read_strobe),
        .write_valid(write_valid),
        .write_data(write_data),
        .file_read_data(file_read_data),
        .done(done),
        .rx_data(rx_data),
        .sb_read_data(sb_read_data),
        .sb_ready(sb_ready),
        .write_ready(write_ready),
        .file_write_enable(file_write_enable),
        .file_address(file_address),
        .file_write_data(file_write_data),
        .start(start),
        .tx_data(tx_data),
        .length(length),
        .divider(divider),
        .clock_polarity(clock_polarity),
        .ss_polarity(ss_polarity)
    );

    spi_register_file #(
        .REGISTER_COUNT(REGISTER_COUNT)
    ) spi_register_file_inst (
        .clock(clock),
        .reset(reset),
        .write_enable(file_write_enable),
        .address(file_address),
        .write_data(file_write_data),
        .read_data(file_read_data)
    );

    spi_shift_engine #(
        .SS_POLARITY_DEFAULT(SS_POLARITY_DEFAULT)
    ) spi_shift_engine_inst (
        .clock(clock),
        .reset(reset),
        .start(start),
        .tx_data(tx_data),
        .length(length),
        .clock_polarity(clock_polarity),
        .ss_polarity(ss_polarity),
        .edge_tick(edge_tick),
        .miso(miso),
        .run(run),
        .sclk(sclk),
        .mosi(mosi),
        .ss(ss),
        .done(done),
        .rx_data(rx_data)
    );

    spi_clock_divider spi_clock_divider_inst (
        .clock(clock),
        .reset(reset),
        .run(run),
        .divider(divider),
        .edge_tick(edge_tick)
    );

endmodule

/* source/spi_pkg.sv */
package spi_pkg;

    // Data and bus word
    typedef logic [31:0] spi_word_t;
    // Byte offset from the base address
    typedef logic [7:0] spi_address_t;
    // Half period of sclk is 2**(divider+1) clock cycles
    typedef logic [2:0] divider_t;
    // A transfer is length+1 bits
    typedef logic [4:0] length_t;

    // Register map
    localparam spi_address_t CONTROL_OFFSET = 8'h00;
    localparam spi_address_t TX_DATA_OFFSET = 8'h04;
    localparam spi_address_t START_OFFSET = 8'h08;
    localparam spi_address_t RX_DATA_OFFSET = 8'h10;

    typedef enum logic [1:0] {
        control_idle,
        control_bus_write,
        control_start_transfer,
        control_transfer_busy
    } control_state_t;

    typedef enum logic [1:0] {
        engine_idle,
        engine_select,
        engine_shifting,
        engine_finish
    } engine_state_t;

endpackage

/* source/spi_register_file.sv */
`timescale 1ns/1ps

module spi_register_file #(
    parameter int REGISTER_COUNT = 8
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  write_enable,
    input  spi_pkg::spi_address_t address,
    input  spi_pkg::spi_word_t    write_data,
    output spi_pkg::spi_word_t    read_data
);
    import spi_pkg::*;

    localparam int INDEX_WIDTH = (REGISTER_COUNT > 1) ? $clog2(REGISTER_COUNT) : 1;

    spi_word_t words [REGISTER_COUNT];
    logic [5:0] word_index;

    // Word offset, byte lanes are not used
    assign word_index = address[7:2];

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < REGISTER_COUNT; i++) begin
                words[i] <= '0;
            end
        end else if (write_enable) begin
            words[word_index[INDEX_WIDTH-1:0]] <= write_data;
        end
    end

    // Offsets past the last word read as zero
    assign read_data = (word_index < REGISTER_COUNT) ? words[word_index[INDEX_WIDTH-1:0]] : '0;

endmodule

/* source/spi_shift_engine.sv */
`timescale 1ns/1ps

module spi_shift_engine #(
    parameter bit SS_POLARITY_DEFAULT = 1'b0
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               start,
    input  spi_pkg::spi_word_t tx_data,
    input  spi_pkg::length_t   length,
    input  logic               clock_polarity,
    input  logic               ss_polarity,
    input  logic               edge_tick,
    input  logic               miso,
    output logic               run,
    output logic               sclk,
    output logic               mosi,
    output logic               ss,
    output logic               done,
    output spi_pkg::spi_word_t rx_data
);
    import spi_pkg::*;

    engine_state_t state;
    spi_word_t shift_register;
    spi_word_t receive_register;
    length_t bits_left;
    logic leading_edge;

    assign run = (state == engine_shifting);

    // sclk at its idle level, so the next toggle is a leading edge
    assign leading_edge = (sclk == clock_polarity);

    // Shift datapath
    always_ff @(posedge clock) begin
        if (state == engine_idle && start) begin
            // Align bit (length) with the MSB
            shift_register <= tx_data << (5'd31 - length);
            receive_register <= '0;
        end else if (run && edge_tick) begin
            if (leading_edge) begin
                shift_register <= shift_register << 1;
            end else begin
                receive_register <= {receive_register[30:0], miso};
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= engine_idle;
            sclk <= 1'b0;
            ss <= ~SS_POLARITY_DEFAULT;
            mosi <= 1'b0;
            done <= 1'b0;
            bits_left <= '0;
            rx_data <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                engine_idle: begin
                    sclk <= clock_polarity;
                    if (start) begin
                        ss <= ss_polarity;
                        bits_left <= length;
                        state <= engine_select;
                    end else begin
                        ss <= ~ss_polarity;
                    end
                end
                engine_select: begin
                    // Present the first bit ahead of the first clock edge
                    mosi <= shift_register[31];
                    state <= engine_shifting;
                end
                engine_shifting: begin
                    if (edge_tick) begin
                        sclk <= ~sclk;
                        if (leading_edge) begin
                            mosi <= shift_register[31];
                        end else if (bits_left == '0) begin
                            state <= engine_finish;
                        end else begin
                            bits_left <= bits_left - 1'b1;
                        end
                    end
                end
                engine_finish: begin
                    sclk <= clock_polarity;
                    ss <= ~ss_polarity;
                    rx_data <= receive_register;
                    done <= 1'b1;
                    state <= engine_idle;
                end
                default: begin
                    state <= engine_idle;
                end
            endcase
        end
    end

endmodule

/* spi_master.f */
source/spi_pkg.sv
source/spi_register_file.sv
source/spi_clock_divider.sv
source/spi_shift_engine.sv
source/spi_control_unit.sv
source/spi_master.sv
test/spi_master_asserts.sv
test/spi_master_tb.sv

/* test/spi_master_asserts.sv */
`timescale 1ns/1ps

module spi_master_asserts (
    input logic clock,
    input logic reset,
    input logic start,
    input logic done,
    input logic sb_ready,
    input logic run,
    input logic edge_tick,
    input logic ss,
    input logic ss_polarity
);

    logic in_transfer;

    // Open from the start pulse until done
    always_ff @(posedge clock) begin
        if (!reset) begin
            in_transfer <= 1'b0;
        end else if (start) begin
            in_transfer <= 1'b1;
        end else if (done) begin
            in_transfer <= 1'b0;
        end
    end

    start_single_cycle: assert property (@(posedge clock) disable iff (!reset)
        start |=> !start)
        else $error("start pulse lasted more than one cycle");

    // Every sclk toggle comes from a tick while shifting
    select_while_toggling: assert property (@(posedge clock) disable iff (!reset)
        (run && edge_tick) |-> (ss == ss_polarity))
        else $error("sclk toggled while slave select was inactive");

    ready_low_in_transfer: assert property (@(posedge clock) disable iff (!reset)
        (start || in_transfer) |-> !sb_ready)
        else $error("sb_ready high between start and done");

    done_after_release: assert property (@(posedge clock) disable iff (!reset)
        done |-> (ss != ss_polarity))
        else $error("done pulsed while slave select was active");

endmodule

// Control and engine signals meet at the top level
bind spi_master spi_master_asserts master_asserts_inst (
    .clock(clock),
    .reset(reset),
    .start(start),
    .done(done),
    .sb_ready(sb_ready),
    .run(run),
    .edge_tick(edge_tick),
    .ss(ss),
    .ss_polarity(ss_polarity)
);

/* test/spi_master_tb.sv */
`timescale 1ns/1ps

module spi_master_tb;
    import spi_pkg::*;

    localparam spi_word_t BASE_ADDRESS = 32'h43c0_0000;
    localparam bit SS_POLARITY_DEFAULT = 1'b0;
    localparam spi_address_t SPARE_OFFSET = 8'h0c;
    // 32 bits of two half periods at the slowest divider
    localparam int LONGEST_TRANSFER = 32 * 2 * 256 + 16;

    typedef enum logic [1:0] {
        op_write,
        op_read,
        op_stream,
        op_pins
    } operation_t;

    typedef struct packed {
        operation_t operation;
        spi_address_t offset;
        spi_word_t data;
        spi_word_t expected;
    } entry_t;

    logic clock;
    logic reset;
    spi_word_t sb_address;
    spi_word_t sb_write_data;
    logic sb_write_strobe;
    logic sb_read_strobe;
    logic write_valid;
    spi_word_t write_data;
    logic miso;
    spi_word_t sb_read_data;
    logic sb_ready;
    logic write_ready;
    logic sclk;
    logic mosi;
    logic ss;

    entry_t entries[$];
    integer seed;
    int error_count = 0;
    int failed_tests = 0;
    int cycle_count = 0;
    int cycle_limit = LONGEST_TRANSFER;

    // Loopback, held low during reset
    assign miso = reset ? mosi : 1'b0;

    spi_master #(
        .BASE_ADDRESS(BASE_ADDRESS),
        .SS_POLARITY_DEFAULT(SS_POLARITY_DEFAULT),
        .REGISTER_COUNT(8)
    ) spi_master_inst (
        .clock(clock),
        .reset(reset),
        .sb_address(sb_address),
        .sb_write_data(sb_write_data),
        .sb_write_strobe(sb_write_strobe),
        .sb_read_strobe(sb_read_strobe),
        .write_valid(write_valid),
        .write_data(write_data),
        .miso(miso),
        .sb_read_data(sb_read_data),
        .sb_ready(sb_ready),
        .write_ready(write_ready),
        .sclk(sclk),
        .mosi(mosi),
        .ss(ss)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic spi_word_t control_word(input divider_t divider, input length_t length,
                                               input logic clock_polarity,
                                               input logic ss_polarity);
        return {22'd0, ss_polarity, clock_polarity, length, divider};
    endfunction

    // Only the low length+1 bits come back
    function automatic spi_word_t low_bits(input spi_word_t word, input length_t length);
        spi_word_t mask;
        mask = 32'hffff_ffff >> (31 - int'(length));
        return word & mask;
    endfunction

    task automatic check_word(input string what, input spi_word_t actual,
                              input spi_word_t expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s, got 0x%08h, expected 0x%08h",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_level(input string what, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s, got %b, expected %b",
                     $time, what, actual, expected);
            error_count++;
        end
    endtask

    task automatic add_entry(input operation_t operation, input spi_address_t offset,
                             input spi_word_t data, input spi_word_t expected);
        entries.push_back('{operation, offset, data, expected});
    endtask

    task automatic build_table();
        spi_word_t words [6];
        spi_word_t settings_a;
        spi_word_t settings_b;
        spi_word_t settings_c;
        spi_word_t settings_d;
        for (int i = 0; i < 6; i++) begin
            words[i] = $random(seed);
        end
        settings_a = control_word(3'd1, 5'd7, 1'b0, 1'b0);
        settings_b = control_word(3'd0, 5'd31, 1'b0, 1'b0);
        settings_c = control_word(3'd3, 5'd12, 1'b0, 1'b0);
        settings_d = control_word(3'd7, 5'd3, 1'b1, 1'b1);
        // Register file cleared by reset
        add_entry(op_read, CONTROL_OFFSET, '0, '0);
        add_entry(op_read, RX_DATA_OFFSET, '0, '0);
        add_entry(op_write, CONTROL_OFFSET, settings_a, '0);
        add_entry(op_read, CONTROL_OFFSET, '0, settings_a);
        add_entry(op_write, TX_DATA_OFFSET, words[0], '0);
        add_entry(op_read, TX_DATA_OFFSET, '0, words[0]);
        add_entry(op_write, SPARE_OFFSET, 32'h5a3c_96e1, '0);
        add_entry(op_read, SPARE_OFFSET, '0, 32'h5a3c_96e1);
        add_entry(op_write, START_OFFSET, '0, '0);
        add_entry(op_read, RX_DATA_OFFSET, '0, low_bits(words[0], 5'd7));
        add_entry(op_write, CONTROL_OFFSET, settings_b, '0);
        add_entry(op_write, TX_DATA_OFFSET, words[1], '0);
        add_entry(op_write, START_OFFSET, '0, '0);
        add_entry(op_read, RX_DATA_OFFSET, '0, low_bits(words[1], 5'd31));
        add_entry(op_write, CONTROL_OFFSET, settings_c, '0);
        add_entry(op_write, TX_DATA_OFFSET, words[2], '0);
        add_entry(op_write, START_OFFSET, '0, '0);
        add_entry(op_read, RX_DATA_OFFSET, '0, low_bits(words[2], 5'd12));
        add_entry(op_stream, '0, words[3], '0);
        add_entry(op_read, RX_DATA_OFFSET, '0, low_bits(words[3], 5'd12));
        add_entry(op_read, CONTROL_OFFSET, '0, settings_c);
        // Idle pins, bit 1 is ss and bit 0 is sclk
        add_entry(op_write, CONTROL_OFFSET, settings_d, '0);
        add_entry(op_pins, '0, '0, 32'h1);
        add_entry(op_write, TX_DATA_OFFSET, words[4], '0);
        add_entry(op_write, START_OFFSET, '0, '0);
        add_entry(op_pins, '0, '0, 32'h1);
        add_entry(op_read, RX_DATA_OFFSET, '0, low_bits(words[4], 5'd3));
        add_entry(op_stream, '0, words[5], '0);
        add_entry(op_read, RX_DATA_OFFSET, '0, low_bits(words[5], 5'd3));
        add_entry(op_read, CONTROL_OFFSET, '0, settings_d);
    endtask

    task automatic wait_ready();
        while (!sb_ready) begin
            @(negedge clock);
        end
    endtask

    task automatic bus_access(input logic is_write, input spi_address_t offset,
                              input spi_word_t data, output spi_word_t read_value);
        @(posedge clock);
        sb_address <= BASE_ADDRESS + spi_word_t'(offset);
        sb_write_data <= data;
        sb_write_strobe <= is_write;
        sb_read_strobe <= !is_write;
        // Accepted once sb_ready drops, read data is valid in that cycle
        do begin
            @(negedge clock);
        end while (sb_ready);
        read_value = sb_read_data;
        @(posedge clock);
        sb_write_strobe <= 1'b0;
        sb_read_strobe <= 1'b0;
        wait_ready();
    endtask

    task automatic stream_word(input spi_word_t data);
        @(posedge clock);
        write_valid <= 1'b1;
        write_data <= data;
        do begin
            @(negedge clock);
        end while (write_ready);
        check_level("sb_ready after stream accept", sb_ready, 1'b0);
        @(posedge clock);
        write_valid <= 1'b0;
        // Control write during the transfer must be dropped
        sb_address <= BASE_ADDRESS + spi_word_t'(CONTROL_OFFSET);
        sb_write_data <= 32'hffff_ffff;
        sb_write_strobe <= 1'b1;
        @(posedge clock);
        sb_write_strobe <= 1'b0;
        wait_ready();
    endtask

    task automatic apply_entry(input entry_t entry);
        spi_word_t read_value;
        case (entry.operation)
            op_write: begin
                bus_access(1'b1, entry.offset, entry.data, read_value);
            end
            op_read: begin
                bus_access(1'b0, entry.offset, '0, read_value);
                check_word($sformatf("read at offset 0x%02h", entry.offset),
                           read_value, entry.expected);
            end
            op_stream: begin
                stream_word(entry.data);
            end
            default: begin
                check_level("sclk idle level", sclk, entry.expected[0]);
                check_level("ss idle level", ss, entry.expected[1]);
            end
        endcase
    endtask

    initial begin
        int errors_before;
        seed = 47452;
        reset = 1'b0;
        sb_address = '0;
        sb_write_data = '0;
        sb_write_strobe = 1'b0;
        sb_read_strobe = 1'b0;
        write_valid = 1'b0;
        write_data = '0;
        build_table();
        cycle_limit = entries.size() * LONGEST_TRANSFER;
        repeat (4) @(posedge clock);
        reset <= 1'b1;
        @(negedge clock);
        check_level("sb_ready after reset", sb_ready, 1'b1);
        check_level("write_ready after reset", write_ready, 1'b1);
        check_level("ss after reset", ss, ~SS_POLARITY_DEFAULT);
        check_level("sclk after reset", sclk, 1'b0);
        $display("test reset levels: %s", (error_count == 0) ? "ok" : "error");
        failed_tests = (error_count == 0) ? 0 : 1;
        for (int i = 0; i < entries.size(); i++) begin
            errors_before = error_count;
            apply_entry(entries[i]);
            $display("test %0d %s offset 0x%02h: %s", i, entries[i].operation.name(),
                     entries[i].offset, (error_count == errors_before) ? "ok" : "error");
            if (error_count != errors_before) begin
                failed_tests++;
            end
        end
        $display("tests %0d, passed %0d, failed %0d, check errors %0d", entries.size() + 1,
                 entries.size() + 1 - failed_tests, failed_tests, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
